// File: dv/frontend_checker.sv
// Watches the DUT ports and compares them with the expected values each
// time the testbench raises check_en. Prints one line per step and keeps
// the pass and fail counts for the closing summary.

`timescale 1ns/1ps
`default_nettype none

module frontend_checker
	import frontend_pkg::*;
(
	input  wire logic        clk_72,
	input  wire logic        check_en,
	input  wire logic [31:0] line_no,
	input  wire port_byte_t  exp_p1,
	input  wire port_byte_t  exp_p2,
	input  wire port_byte_t  exp_sys,
	input  wire logic        exp_rst,
	input  wire port_byte_t  p1_port,
	input  wire port_byte_t  p2_port,
	input  wire port_byte_t  sys_port,
	input  wire logic        core_reset,
	output int               pass_count,
	output int               fail_count
);

	// Reports one field and returns 1 when it differs
	function automatic bit field_differs(input string name, input logic [7:0] exp_v,
		input logic [7:0] act_v);
		if (act_v !== exp_v) begin
			$display("Error at %0d ns: line %0d %s expected %02h, got %02h",
				$time, line_no, name, exp_v, act_v);
			return 1'b1;
		end
		return 1'b0;
	endfunction

	initial begin
		pass_count = 0;
		fail_count = 0;
	end

	// ========================================================================
	// Compare on the rising edge once the ports have settled
	// ========================================================================
	always @(posedge clk_72) begin : compare_step
		bit bad;
		if (check_en) begin
			bad = 1'b0;
			bad = field_differs("p1_port", exp_p1, p1_port) | bad;
			bad = field_differs("p2_port", exp_p2, p2_port) | bad;
			bad = field_differs("sys_port", exp_sys, sys_port) | bad;
			bad = field_differs("core_reset", {7'b0, exp_rst}, {7'b0, core_reset}) | bad;
			if (bad) begin
				fail_count++;
				$display("Step at line %0d: FAIL", line_no);
			end else begin
				pass_count++;
				$display("Step at line %0d: ok", line_no);
			end
		end
	end

endmodule

`default_nettype wire

// File: dv/frontend_vectors.txt
# op arg1 [arg2] exp_p1 exp_p2 exp_sys exp_core_reset, all hex
# key code pressed | joy j0 j1 | opt rotate joyswap | dl level | rst status button
rst 0 0    00 00 00 1
dl 1       00 00 00 1
dl 0       00 00 00 0
rst 1 0    00 00 00 1
rst 0 1    00 00 00 1
rst 0 0    00 00 00 0
key 75 1   01 00 00 0
key 74 1   09 00 00 0
key 14 1   19 00 00 0
key 75 0   18 00 00 0
key 2D 1   18 01 00 0
key 16 1   18 01 04 0
key 06 1   18 01 44 0
key 5A 1   18 01 44 0
key 74 0   10 01 44 0
key 14 0   00 01 44 0
key 2D 0   00 00 44 0
key 16 0   00 00 40 0
key 06 0   00 00 00 0
joy 18 82  11 04 08 0
key 2B 1   11 06 08 0
opt 0 1    04 10 04 0
key 2B 0   04 11 04 0
joy 00 00  00 00 00 0
opt 1 0    00 00 00 0
joy 08 00  08 00 00 0
joy 01 00  02 00 00 0
joy 04 00  04 00 00 0
joy 02 00  01 00 00 0
joy 1C 00  10 00 00 0
joy 00 23  00 20 00 0
key 72 1   04 20 00 0
opt 0 0    02 20 00 0

// File: dv/tb_arcade_frontend.sv
// Testbench top for the arcade control front end. Reads one step per line
// from the vector file, drives the DUT on the falling clock edge and hands
// the expected bytes to the checker four cycles later.
// Run from the project root so the vector file path resolves.

`timescale 1ns/1ps
`default_nettype none

module tb_arcade_frontend
	import frontend_pkg::*;
();

	logic       clk_72;
	logic       arst_n;
	logic       key_strobe;
	logic       key_pressed;
	scan_code_t key_code;
	joy_word_t  joystick_0;
	joy_word_t  joystick_1;
	logic       joyswap;
	logic       rotate;
	logic       ioctl_download;
	logic       status_reset;
	logic       button_reset;
	port_byte_t p1_port;
	port_byte_t p2_port;
	port_byte_t sys_port;
	logic       core_reset;

	// Checker side
	logic       check_en;
	int         line_no;
	port_byte_t exp_p1;
	port_byte_t exp_p2;
	port_byte_t exp_sys;
	logic       exp_rst;
	int         pass_count;
	int         fail_count;
	int         step_count;
	int         bad_lines;
	logic       run_started;

	arcade_frontend u_dut (.*);

	frontend_checker u_checker (.*);

	always #10 clk_72 = ~clk_72;

	// Non-comment lines of the vector file
	task count_steps(input int fd, output int n);
		reg [8*128-1:0] text;
		reg [63:0]      op;
		n = 0;
		while (!$feof(fd)) begin
			text = '0;
			if ($fgets(text, fd) != 0 && $sscanf(text, "%s", op) == 1 && op != "#")
				n++;
		end
	endtask

	// Levels hold until a later line changes them
	task apply_step(input logic [63:0] op, input logic [7:0] a, input logic [7:0] b);
		case (op)
			"key": begin
				key_code    = a;
				key_pressed = b[0];
				key_strobe  = 1'b1;
			end
			"joy": begin
				joystick_0 = a;
				joystick_1 = b;
			end
			"opt": begin
				rotate  = a[0];
				joyswap = b[0];
			end
			"dl": ioctl_download = a[0];
			"rst": begin
				status_reset = a[0];
				button_reset = b[0];
			end
			default: begin
				$display("Unknown operation on line %0d of the vector file", line_no);
				bad_lines++;
			end
		endcase
	endtask

	// ========================================================================
	// Watchdog, sized from the number of steps
	// ========================================================================
	initial begin
		wait (run_started);
		#(step_count * 6 * 20 + 1000);
		$display("Timeout: the run did not finish in the time allowed for %0d steps",
			step_count);
		$display("Result: FAILED");
		$finish;
	end

	// ========================================================================
	// Reset, vector reader and stimulus
	// ========================================================================
	initial begin : run_vectors
		int             fd;
		int             n;
		int             fields;
		reg [8*128-1:0] text;
		reg [63:0]      op;
		logic [7:0]     a;
		logic [7:0]     b;
		logic [7:0]     e1;
		logic [7:0]     e2;
		logic [7:0]     e3;
		logic           er;
		clk_72         = 1'b0;
		arst_n         = 1'b0;
		key_strobe     = 1'b0;
		key_pressed    = 1'b0;
		key_code       = '0;
		joystick_0     = '0;
		joystick_1     = '0;
		joyswap        = 1'b0;
		rotate         = 1'b0;
		ioctl_download = 1'b0;
		status_reset   = 1'b0;
		button_reset   = 1'b0;
		check_en       = 1'b0;
		line_no        = 0;
		exp_p1         = '0;
		exp_p2         = '0;
		exp_sys        = '0;
		exp_rst        = 1'b1;
		step_count     = 0;
		bad_lines      = 0;
		run_started    = 1'b0;
		fd = $fopen("dv/frontend_vectors.txt", "r");
		if (fd == 0) begin
			$display("Cannot open the vector file dv/frontend_vectors.txt");
			$display("Result: FAILED");
			$finish;
		end else begin
			count_steps(fd, step_count);
			$fclose(fd);
			run_started = 1'b1;
			repeat (4) @(posedge clk_72);
			@(negedge clk_72);
			arst_n = 1'b1;
			fd = $fopen("dv/frontend_vectors.txt", "r");
			while (!$feof(fd)) begin
				text = '0;
				n = $fgets(text, fd);
				line_no++;
				if (n != 0 && $sscanf(text, "%s", op) == 1 && op != "#") begin
					b = '0;
					// A download line carries a single operand
					if (op == "dl")
						fields = $sscanf(text, "%s %h %h %h %h %h", op, a, e1, e2, e3, er) + 1;
					else
						fields = $sscanf(text, "%s %h %h %h %h %h %h",
							op, a, b, e1, e2, e3, er);
					if (fields != 7) begin
						$display("Malformed vector on line %0d", line_no);
						bad_lines++;
					end
					apply_step(op, a, b);
					@(negedge clk_72);
					key_strobe = 1'b0;
					repeat (3) @(negedge clk_72);
					exp_p1   = e1;
					exp_p2   = e2;
					exp_sys  = e3;
					exp_rst  = er;
					check_en = 1'b1;
					@(negedge clk_72);
					check_en = 1'b0;
				end
			end
			$fclose(fd);
			@(negedge clk_72);
			$display("Steps: %0d passed, %0d failed", pass_count, fail_count);
			if (fail_count == 0 && bad_lines == 0 && step_count > 0 &&
				pass_count == step_count)
				$display("Result: PASSED");
			else
				$display("Result: FAILED");
			$finish;
		end
	end

endmodule

`default_nettype wire

// File: logic/arcade_frontend.sv
// Top level of the control front end. Sits between the firmware link
// and the arcade core: key strobes and joystick words come in, three
// registered input bytes and the core reset go out. Key changes reach the
// ports after 3 cycles, joystick and option changes after 2.

`timescale 1ns/1ps
`default_nettype none

module arcade_frontend
	import frontend_pkg::*;
(
	input  wire logic       clk_72,
	input  wire logic       arst_n,
	// Keyboard strobe from the firmware link
	input  wire logic       key_strobe,
	input  wire logic       key_pressed,
	input  wire scan_code_t key_code,
	// Joysticks and menu options
	input  wire joy_word_t  joystick_0,
	input  wire joy_word_t  joystick_1,
	input  wire logic       joyswap,
	input  wire logic       rotate,
	// Reset sources
	input  wire logic       ioctl_download,
	input  wire logic       status_reset,
	input  wire logic       button_reset,
	// To the arcade core
	output port_byte_t      p1_port,
	output port_byte_t      p2_port,
	output port_byte_t      sys_port,
	output logic            core_reset
);

	key_vec_t     held_keys;
	player_ctrl_t p1_ctrl;
	player_ctrl_t p2_ctrl;
	port_byte_t   sys_ctrl;

	// ========================================================================
	// Input pipeline
	// ========================================================================
	key_decode u_key_decode (
		.clk_72      (clk_72),
		.arst_n      (arst_n),
		.key_strobe  (key_strobe),
		.key_pressed (key_pressed),
		.key_code    (key_code),
		.held_keys   (held_keys)
	);

	control_mapper u_control_mapper (
		.clk_72     (clk_72),
		.arst_n     (arst_n),
		.held_keys  (held_keys),
		.joystick_0 (joystick_0),
		.joystick_1 (joystick_1),
		.joyswap    (joyswap),
		.rotate     (rotate),
		.p1_ctrl    (p1_ctrl),
		.p2_ctrl    (p2_ctrl),
		.sys_ctrl   (sys_ctrl)
	);

	port_builder u_port_builder (
		.clk_72   (clk_72),
		.arst_n   (arst_n),
		.p1_ctrl  (p1_ctrl),
		.p2_ctrl  (p2_ctrl),
		.sys_ctrl (sys_ctrl),
		.p1_port  (p1_port),
		.p2_port  (p2_port),
		.sys_port (sys_port)
	);

	// Runs alongside the pipeline
	reset_sequencer u_reset_sequencer (
		.clk_72         (clk_72),
		.arst_n         (arst_n),
		.ioctl_download (ioctl_download),
		.status_reset   (status_reset),
		.button_reset   (button_reset),
		.core_reset     (core_reset)
	);

endmodule

`default_nettype wire

// File: logic/control_mapper.sv
// Execute stage. Merges the firmware joystick words with the held keys,
// applies the joystick-swap and rotate-controls options, and gathers the
// system keys into one byte. All outputs are registered, one cycle after
// the inputs change.

`timescale 1ns/1ps
`default_nettype none

module control_mapper
	import frontend_pkg::*;
	import keymap_pkg::*;
(
	input  wire logic      clk_72,
	input  wire logic      arst_n,
	input  wire key_vec_t  held_keys,
	input  wire joy_word_t joystick_0,
	input  wire joy_word_t joystick_1,
	input  wire logic      joyswap,
	input  wire logic      rotate,
	output player_ctrl_t   p1_ctrl,
	output player_ctrl_t   p2_ctrl,
	output port_byte_t     sys_ctrl
);

	player_ctrl_t p1_joy;
	player_ctrl_t p2_joy;
	player_ctrl_t p1_keys;
	player_ctrl_t p2_keys;
	player_ctrl_t p1_mix;
	player_ctrl_t p2_mix;
	port_byte_t   sys_next;

	// Quarter turn clockwise, fire and start bits pass unchanged
	function automatic player_ctrl_t turn_cw(input player_ctrl_t c);
		player_ctrl_t r;
		r = c;
		r[joy_up]    = c[joy_left];
		r[joy_right] = c[joy_up];
		r[joy_down]  = c[joy_right];
		r[joy_left]  = c[joy_down];
		return r;
	endfunction

	// ========================================================================
	// Swap, key merge and system byte
	// ========================================================================
	always_comb begin
		p1_joy = joyswap ? joystick_1 : joystick_0;
		p2_joy = joyswap ? joystick_0 : joystick_1;

		// Keys laid out in joystick word order
		p1_keys            = '0;
		p1_keys[joy_right] = held_keys[key_p1_right];
		p1_keys[joy_left]  = held_keys[key_p1_left];
		p1_keys[joy_down]  = held_keys[key_p1_down];
		p1_keys[joy_up]    = held_keys[key_p1_up];
		p1_keys[joy_fire1] = held_keys[key_p1_fire1];
		p1_keys[joy_fire2] = held_keys[key_p1_fire2];
		p1_keys[joy_fire3] = held_keys[key_p1_fire3];
		p1_keys[joy_start] = held_keys[key_start1];

		p2_keys            = '0;
		p2_keys[joy_right] = held_keys[key_p2_right];
		p2_keys[joy_left]  = held_keys[key_p2_left];
		p2_keys[joy_down]  = held_keys[key_p2_down];
		p2_keys[joy_up]    = held_keys[key_p2_up];
		p2_keys[joy_fire1] = held_keys[key_p2_fire1];
		p2_keys[joy_fire2] = held_keys[key_p2_fire2];
		p2_keys[joy_fire3] = held_keys[key_p2_fire3];
		p2_keys[joy_start] = held_keys[key_start2];

		p1_mix = p1_joy | p1_keys;
		p2_mix = p2_joy | p2_keys;

		// Start positions follow the swapped joysticks as well as the keys
		sys_next              = '0;
		sys_next[sys_coin1]   = held_keys[key_coin1];
		sys_next[sys_coin2]   = held_keys[key_coin2];
		sys_next[sys_start1]  = p1_mix[joy_start];
		sys_next[sys_start2]  = p2_mix[joy_start];
		sys_next[sys_service] = held_keys[key_service];
		sys_next[sys_tilt]    = held_keys[key_tilt];
		sys_next[sys_test]    = held_keys[key_test];
	end

	// ========================================================================
	// Output registers
	// ========================================================================
	always_ff @(posedge clk_72 or negedge arst_n) begin
		if (!arst_n) begin
			p1_ctrl  <= '0;
			p2_ctrl  <= '0;
			sys_ctrl <= '0;
		end else begin
			p1_ctrl  <= rotate ? turn_cw(p1_mix) : p1_mix;
			p2_ctrl  <= rotate ? turn_cw(p2_mix) : p2_mix;
			sys_ctrl <= sys_next;
		end
	end

endmodule

`default_nettype wire

// File: logic/frontend_pkg.sv
// Shared widths, vector types and the ROM-state encoding for the arcade
// control front end. The RTL blocks and the testbench both import it.
// Bit positions of the firmware joystick word, the player port bytes and
// the system port byte are kept here so every stage agrees on them.

`default_nettype none

package frontend_pkg;

	// ========================================================================
	// Widths and vector types
	// ========================================================================
	localparam int scan_w = 8;
	localparam int joy_w  = 8;
	localparam int key_w  = 24;
	localparam int port_w = 8;

	typedef logic [scan_w-1:0] scan_code_t;
	typedef logic [joy_w-1:0]  joy_word_t;
	typedef logic [joy_w-1:0]  player_ctrl_t;
	typedef logic [key_w-1:0]  key_vec_t;
	typedef logic [port_w-1:0] port_byte_t;

	typedef enum logic [1:0] {
		rom_empty,
		rom_loading,
		rom_ready
	} rom_state_t;

	// Firmware joystick word, also the player_ctrl_t order
	localparam int joy_right = 0;
	localparam int joy_left  = 1;
	localparam int joy_down  = 2;
	localparam int joy_up    = 3;
	localparam int joy_fire1 = 4;
	localparam int joy_fire2 = 5;
	localparam int joy_fire3 = 6;
	localparam int joy_start = 7;

	// Arcade player byte, bit 7 unused
	localparam int port_up    = 0;
	localparam int port_down  = 1;
	localparam int port_left  = 2;
	localparam int port_right = 3;
	localparam int port_fire1 = 4;
	localparam int port_fire2 = 5;
	localparam int port_fire3 = 6;

	// System byte, bit 7 always 0
	localparam int sys_coin1   = 0;
	localparam int sys_coin2   = 1;
	localparam int sys_start1  = 2;
	localparam int sys_start2  = 3;
	localparam int sys_service = 4;
	localparam int sys_tilt    = 5;
	localparam int sys_test    = 6;

endpackage

`default_nettype wire

// File: logic/key_decode.sv
// Decode stage. Each key strobe carries a scan code and a press or
// release flag; known codes set or clear one bit of the held-key vector.
// The vector updates on the clock edge after the strobe is sampled.
// Unknown codes leave the vector untouched.

`timescale 1ns/1ps
`default_nettype none

module key_decode
	import frontend_pkg::*;
	import keymap_pkg::*;
(
	input  wire logic       clk_72,
	input  wire logic       arst_n,
	input  wire logic       key_strobe,
	input  wire logic       key_pressed,
	input  wire scan_code_t key_code,
	output key_vec_t        held_keys
);

	key_idx_t key_idx;
	logic     key_hit;

	// ========================================================================
	// Scan code lookup
	// ========================================================================
	always_comb begin
		key_hit = 1'b1;
		key_idx = '0;
		case (key_code)
			sc_kp8:   key_idx = key_p1_up;
			sc_kp2:   key_idx = key_p1_down;
			sc_kp4:   key_idx = key_p1_left;
			sc_kp6:   key_idx = key_p1_right;
			sc_lctrl: key_idx = key_p1_fire1;
			sc_lalt:  key_idx = key_p1_fire2;
			sc_space: key_idx = key_p1_fire3;
			sc_r:     key_idx = key_p2_up;
			sc_f:     key_idx = key_p2_down;
			sc_d:     key_idx = key_p2_left;
			sc_g:     key_idx = key_p2_right;
			sc_a:     key_idx = key_p2_fire1;
			sc_s:     key_idx = key_p2_fire2;
			sc_q:     key_idx = key_p2_fire3;
			sc_1:     key_idx = key_start1;
			sc_2:     key_idx = key_start2;
			sc_5:     key_idx = key_coin1;
			sc_6:     key_idx = key_coin2;
			sc_9:     key_idx = key_service;
			sc_t:     key_idx = key_tilt;
			sc_f2:    key_idx = key_test;
			default:  key_hit = 1'b0;
		endcase
	end

	// ========================================================================
	// Held-key register
	// ========================================================================
	// Spare bits 21..23 are never addressed and stay at their reset value
	always_ff @(posedge clk_72 or negedge arst_n) begin
		if (!arst_n) begin
			held_keys <= '0;
		end else if (key_strobe && key_hit) begin
			held_keys[key_idx] <= key_pressed;
		end
	end

endmodule

`default_nettype wire

// File: logic/keymap_pkg.sv
// PS/2 set-2 scan codes recognized by the key decoder, and the bit each
// key occupies in the held-key vector. Keys fill bits 0 to 20 in the
// order below; the remaining bits of the vector are spare.

`default_nettype none

package keymap_pkg;

	localparam int key_idx_w = 5;
	typedef logic [key_idx_w-1:0] key_idx_t;

	// ========================================================================
	// Scan codes
	// ========================================================================
	localparam logic [7:0] sc_kp8   = 8'h75;
	localparam logic [7:0] sc_kp2   = 8'h72;
	localparam logic [7:0] sc_kp4   = 8'h6B;
	localparam logic [7:0] sc_kp6   = 8'h74;
	localparam logic [7:0] sc_lctrl = 8'h14;
	localparam logic [7:0] sc_lalt  = 8'h11;
	localparam logic [7:0] sc_space = 8'h29;
	localparam logic [7:0] sc_r     = 8'h2D;
	localparam logic [7:0] sc_f     = 8'h2B;
	localparam logic [7:0] sc_d     = 8'h23;
	localparam logic [7:0] sc_g     = 8'h34;
	localparam logic [7:0] sc_a     = 8'h1C;
	localparam logic [7:0] sc_s     = 8'h1B;
	localparam logic [7:0] sc_q     = 8'h15;
	localparam logic [7:0] sc_1     = 8'h16;
	localparam logic [7:0] sc_2     = 8'h1E;
	localparam logic [7:0] sc_5     = 8'h2E;
	localparam logic [7:0] sc_6     = 8'h36;
	localparam logic [7:0] sc_9     = 8'h46;
	localparam logic [7:0] sc_t     = 8'h2C;
	localparam logic [7:0] sc_f2    = 8'h06;

	// ========================================================================
	// Held-key vector positions
	// ========================================================================
	localparam key_idx_t key_p1_up    = 5'd0;
	localparam key_idx_t key_p1_down  = 5'd1;
	localparam key_idx_t key_p1_left  = 5'd2;
	localparam key_idx_t key_p1_right = 5'd3;
	localparam key_idx_t key_p1_fire1 = 5'd4;
	localparam key_idx_t key_p1_fire2 = 5'd5;
	localparam key_idx_t key_p1_fire3 = 5'd6;
	localparam key_idx_t key_p2_up    = 5'd7;
	localparam key_idx_t key_p2_down  = 5'd8;
	localparam key_idx_t key_p2_left  = 5'd9;
	localparam key_idx_t key_p2_right = 5'd10;
	localparam key_idx_t key_p2_fire1 = 5'd11;
	localparam key_idx_t key_p2_fire2 = 5'd12;
	localparam key_idx_t key_p2_fire3 = 5'd13;
	localparam key_idx_t key_start1   = 5'd14;
	localparam key_idx_t key_start2   = 5'd15;
	localparam key_idx_t key_coin1    = 5'd16;
	localparam key_idx_t key_coin2    = 5'd17;
	localparam key_idx_t key_service  = 5'd18;
	localparam key_idx_t key_tilt     = 5'd19;
	localparam key_idx_t key_test     = 5'd20;

endpackage

`default_nettype wire

// File: logic/port_builder.sv
// Result stage. Reorders each player's controls into the arcade byte
// layout, drops opposing directions held together, and registers the two
// player bytes and the system byte. Outputs are active high.

`timescale 1ns/1ps
`default_nettype none

module port_builder
	import frontend_pkg::*;
(
	input  wire logic         clk_72,
	input  wire logic         arst_n,
	input  wire player_ctrl_t p1_ctrl,
	input  wire player_ctrl_t p2_ctrl,
	input  wire port_byte_t   sys_ctrl,
	output port_byte_t        p1_port,
	output port_byte_t        p2_port,
	output port_byte_t        sys_port
);

	port_byte_t p1_next;
	port_byte_t p2_next;

	// Arcade player byte from joystick-ordered controls
	function automatic port_byte_t player_byte(input player_ctrl_t c);
		port_byte_t b;
		logic       ud_clash;
		logic       lr_clash;
		ud_clash = c[joy_up] & c[joy_down];
		lr_clash = c[joy_left] & c[joy_right];
		b             = '0;
		b[port_up]    = c[joy_up] & ~ud_clash;
		b[port_down]  = c[joy_down] & ~ud_clash;
		b[port_left]  = c[joy_left] & ~lr_clash;
		b[port_right] = c[joy_right] & ~lr_clash;
		b[port_fire1] = c[joy_fire1];
		b[port_fire2] = c[joy_fire2];
		b[port_fire3] = c[joy_fire3];
		return b;
	endfunction

	always_comb begin
		p1_next = player_byte(p1_ctrl);
		p2_next = player_byte(p2_ctrl);
	end

	// ========================================================================
	// Port registers
	// ========================================================================
	always_ff @(posedge clk_72 or negedge arst_n) begin
		if (!arst_n) begin
			p1_port  <= '0;
			p2_port  <= '0;
			sys_port <= '0;
		end else begin
			p1_port  <= p1_next;
			p2_port  <= p2_next;
			// Top bit of the system byte is unused
			sys_port <= {1'b0, sys_ctrl[port_w-2:0]};
		end
	end

endmodule

`default_nettype wire

// File: logic/reset_sequencer.sv
// Core reset generation. Tracks the ROM download through a small state
// machine and holds the core in reset until a full download has finished
// and neither the firmware reset bit nor the board button is active.

`timescale 1ns/1ps
`default_nettype none

module reset_sequencer
	import frontend_pkg::*;
(
	input  wire logic clk_72,
	input  wire logic arst_n,
	input  wire logic ioctl_download,
	input  wire logic status_reset,
	input  wire logic button_reset,
	output logic      core_reset
);

	rom_state_t rom_state;

	// ========================================================================
	// ROM load state
	// ========================================================================
	always_ff @(posedge clk_72 or negedge arst_n) begin
		if (!arst_n) begin
			rom_state <= rom_empty;
		end else begin
			case (rom_state)
				rom_empty, rom_ready:
					if (ioctl_download) rom_state <= rom_loading;
				rom_loading:
					if (!ioctl_download) rom_state <= rom_ready;
				default:
					rom_state <= rom_empty;
			endcase
		end
	end

	// Release only once the image is in place
	always_ff @(posedge clk_72 or negedge arst_n) begin
		if (!arst_n) begin
			core_reset <= 1'b1;
		end else begin
			core_reset <= !(rom_state == rom_ready && !ioctl_download &&
				!status_reset && !button_reset);
		end
	end

endmodule

`default_nettype wire

// File: src.f
logic/frontend_pkg.sv
logic/keymap_pkg.sv
logic/key_decode.sv
logic/control_mapper.sv
logic/port_builder.sv
logic/reset_sequencer.sv
logic/arcade_frontend.sv
dv/frontend_checker.sv
dv/tb_arcade_frontend.sv
